//--- source/rename_pkg.sv
// rename and commit shared types
`default_nettype none

package rename_pkg;

	// --------------------
	// widths and counts
	// --------------------
	localparam int AREG_W    = 5;  // 32 logical registers
	localparam int PRF_W     = 6;  // 64 physical registers
	localparam int FREE_N    = 32; // tags held by the free list
	localparam int BR_SLOTS  = 4;  // in-flight branch checkpoints
	localparam int ROB_IDX_W = 3;  // up to 8 rob entries
	localparam int FL_PTR_W  = 5;  // free list slot index

	typedef logic [AREG_W-1:0]    areg_t;
	typedef logic [PRF_W-1:0]     prf_tag_t;
	typedef logic [BR_SLOTS-1:0]  br_mask_t; // one bit per checkpoint slot
	typedef logic [ROB_IDX_W-1:0] rob_idx_t;
	typedef logic [FL_PTR_W-1:0]  fl_ptr_t;

	// --------------------
	// port bundles
	// --------------------

	// instruction offered at dispatch
	typedef struct packed {
		areg_t       logic_dest;
		logic [63:0] pc;
		logic        is_br;
		logic        pred_taken; // predictor said taken
		logic        rd_mem;
		logic        wr_mem;
	} dispatch_req_t;

	// functional unit completion report
	typedef struct packed {
		logic     valid;
		rob_idx_t rob_idx;
		logic     taken; // resolved branch direction
	} fu_done_t;

	// instruction leaving the head of the rob
	typedef struct packed {
		logic        valid;
		areg_t       logic_dest;
		prf_tag_t    new_tag;
		prf_tag_t    old_tag; // goes back to the free list
		logic [63:0] pc;
		logic        rd_mem;
		logic        wr_mem;
	} retire_t;

	// mispredicted branch announcement
	typedef struct packed {
		logic     valid;
		rob_idx_t rob_idx;
		br_mask_t br_mask; // one-hot slot of the branch
	} recovery_t;

endpackage

`default_nettype wire

//--- source/free_list.sv
// physical tag free list
`default_nettype none

module free_list (
	input  wire  logic                 clk,
	input  wire  logic                 rst,
	input  wire  logic                 pop_i,
	input  wire  logic                 push_i,
	input  wire  rename_pkg::prf_tag_t push_tag_i,
	input  wire  logic                 restore_i,
	input  wire  rename_pkg::fl_ptr_t  restore_head_i,
	output rename_pkg::prf_tag_t       tag_o,
	output rename_pkg::fl_ptr_t        head_o,
	output logic                       empty_o
);

	localparam int PTR_W = rename_pkg::FL_PTR_W;

	rename_pkg::prf_tag_t tags_r [rename_pkg::FREE_N];

	logic [PTR_W:0]   head_r; // wrap bit on top
	logic [PTR_W:0]   tail_r;
	logic [PTR_W-1:0] rollback;

	always_comb begin
		head_o  = head_r[PTR_W-1:0];
		tag_o   = tags_r[head_r[PTR_W-1:0]];
		empty_o = head_r == tail_r;

		// tags popped since the branch snapshot, never more than the rob holds
		rollback = head_r[PTR_W-1:0] - restore_head_i;
	end

	// --------------------
	// pointers
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= {1'b1, {PTR_W{1'b0}}}; // every slot holds a free tag
		end else begin
			if (restore_i)
				head_r <= head_r - {1'b0, rollback};
			else if (pop_i)
				head_r <= head_r + 1'b1;
			if (push_i)
				tail_r <= tail_r + 1'b1;
		end
	end

	// tags above the identity map start free, in ascending order
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rename_pkg::FREE_N; i++) begin
				tags_r[i] <= rename_pkg::prf_tag_t'(rename_pkg::FREE_N + i);
			end
		end else if (push_i) begin
			tags_r[tail_r[PTR_W-1:0]] <= push_tag_i;
		end
	end

	// dispatch never takes a tag from an empty list
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- source/map_table.sv
// speculative map table with checkpoints
`default_nettype none

module map_table (
	input  wire  logic                 clk,
	input  wire  logic                 rst,
	input  wire  logic                 fire_i,
	input  wire  rename_pkg::areg_t    logic_dest_i,
	input  wire  rename_pkg::prf_tag_t new_tag_i,
	input  wire  logic                 is_br_i,
	input  wire  rename_pkg::br_mask_t resolve_mask_i,
	input  wire  logic                 restore_i,
	input  wire  rename_pkg::br_mask_t restore_mask_i,
	output rename_pkg::prf_tag_t       old_tag_o,
	output rename_pkg::br_mask_t       br_mask_o,
	output logic                       slot_free_o
);

	localparam int AREG_N = 2 ** rename_pkg::AREG_W;
	localparam int SLOTS  = rename_pkg::BR_SLOTS;
	localparam int SLOT_W = $clog2(SLOTS);

	rename_pkg::prf_tag_t map_r  [AREG_N];
	rename_pkg::prf_tag_t ckpt_r [SLOTS][AREG_N];
	rename_pkg::br_mask_t busy_r;
	rename_pkg::br_mask_t younger_r [SLOTS]; // bit t set if slot t was taken after this slot

	rename_pkg::br_mask_t alloc_mask;
	logic [SLOT_W-1:0]    alloc_slot;
	logic [SLOT_W-1:0]    restore_slot;
	logic                 br_fire;

	// --------------------
	// slot selection
	// --------------------
	always_comb begin
		alloc_mask = ~busy_r & (busy_r + 1'b1); // lowest free slot, one-hot
		alloc_slot = '0;
		for (int s = SLOTS - 1; s >= 0; s--) begin
			if (!busy_r[s])
				alloc_slot = SLOT_W'(s);
		end

		restore_slot = '0;
		for (int s = 0; s < SLOTS; s++) begin
			if (restore_mask_i[s])
				restore_slot = SLOT_W'(s);
		end

		old_tag_o   = map_r[logic_dest_i];
		br_mask_o   = is_br_i ? alloc_mask : '0;
		slot_free_o = |(~busy_r);
		br_fire     = fire_i && is_br_i;
	end

	// --------------------
	// map and slot state
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_r <= '0;
			for (int s = 0; s < SLOTS; s++) begin
				younger_r[s] <= '0;
			end
			for (int r = 0; r < AREG_N; r++) begin
				map_r[r] <= rename_pkg::prf_tag_t'(r); // identity map
			end
		end else if (restore_i) begin
			for (int r = 0; r < AREG_N; r++) begin
				map_r[r] <= ckpt_r[restore_slot][r];
			end
			// drop the branch and everything dispatched after it
			busy_r <= busy_r & ~(restore_mask_i | younger_r[restore_slot]) & ~resolve_mask_i;
		end else begin
			if (fire_i)
				map_r[logic_dest_i] <= new_tag_i;
			busy_r <= (busy_r & ~resolve_mask_i) | (br_fire ? alloc_mask : '0);
			if (br_fire) begin
				younger_r[alloc_slot] <= '0;
				for (int s = 0; s < SLOTS; s++) begin
					younger_r[s][alloc_slot] <= busy_r[s]; // every live slot is older
				end
			end
		end
	end

	// checkpoint holds the map as it stands after the branch's own rename
	always_ff @(posedge clk) begin
		if (br_fire) begin
			for (int r = 0; r < AREG_N; r++) begin
				if (rename_pkg::areg_t'(r) == logic_dest_i)
					ckpt_r[alloc_slot][r] <= new_tag_i;
				else
					ckpt_r[alloc_slot][r] <= map_r[r];
			end
		end
	end

endmodule

`default_nettype wire

//--- source/rob.sv
// reorder buffer
`default_nettype none

module rob #(
	parameter int ROB_DEPTH = 8
) (
	input  wire  logic                      clk,
	input  wire  logic                      rst,
	input  wire  logic                      fire_i,
	input  wire  rename_pkg::dispatch_req_t disp_i,
	input  wire  rename_pkg::prf_tag_t      new_tag_i,
	input  wire  rename_pkg::prf_tag_t      old_tag_i,
	input  wire  rename_pkg::br_mask_t      br_mask_i,
	input  wire  rename_pkg::fl_ptr_t       fl_head_i,
	input  wire  rename_pkg::fu_done_t      fu_i,
	output logic                            full_o,
	output rename_pkg::rob_idx_t            tail_idx_o,
	output rename_pkg::retire_t             retire_o,
	output rename_pkg::recovery_t           recover_o,
	output rename_pkg::fl_ptr_t             recover_fl_head_o,
	output rename_pkg::br_mask_t            resolve_mask_o
);

	localparam int IDX_W = $clog2(ROB_DEPTH);

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [IDX_W:0]   ptr_t; // extra wrap bit

	// --------------------
	// entry storage
	// --------------------
	rename_pkg::dispatch_req_t disp_r    [ROB_DEPTH];
	rename_pkg::prf_tag_t      new_tag_r [ROB_DEPTH];
	rename_pkg::prf_tag_t      old_tag_r [ROB_DEPTH];
	rename_pkg::br_mask_t      br_mask_r [ROB_DEPTH];
	rename_pkg::fl_ptr_t       fl_head_r [ROB_DEPTH]; // free list head past this entry's tag
	logic [ROB_DEPTH-1:0]      done_r;
	logic [ROB_DEPTH-1:0]      done_nxt;

	ptr_t head_r;
	ptr_t tail_r;
	ptr_t occupancy;
	idx_t head_idx;
	idx_t tail_idx;
	idx_t fu_idx;
	idx_t fu_off;   // completing entry's distance from the head
	logic retire_vld;
	logic comp_br;
	logic mispredict;
	logic [ROB_DEPTH-1:0] squash; // entries younger than a mispredicted branch

	always_comb begin
		head_idx  = head_r[IDX_W-1:0];
		tail_idx  = tail_r[IDX_W-1:0];
		fu_idx    = fu_i.rob_idx[IDX_W-1:0];
		fu_off    = fu_idx - head_idx;
		occupancy = tail_r - head_r;
		full_o    = occupancy == ptr_t'(ROB_DEPTH);

		tail_idx_o = rename_pkg::rob_idx_t'(tail_idx);
		retire_vld = (occupancy != '0) && done_r[head_idx];
	end

	// --------------------
	// retire and recovery
	// --------------------
	always_comb begin
		retire_o.valid      = retire_vld;
		retire_o.logic_dest = disp_r[head_idx].logic_dest;
		retire_o.new_tag    = new_tag_r[head_idx];
		retire_o.old_tag    = old_tag_r[head_idx];
		retire_o.pc         = disp_r[head_idx].pc;
		retire_o.rd_mem     = disp_r[head_idx].rd_mem;
		retire_o.wr_mem     = disp_r[head_idx].wr_mem;

		comp_br    = fu_i.valid && disp_r[fu_idx].is_br;
		mispredict = comp_br && (disp_r[fu_idx].pred_taken != fu_i.taken);

		recover_o.valid   = mispredict;
		recover_o.rob_idx = rename_pkg::rob_idx_t'(fu_idx);
		recover_o.br_mask = br_mask_r[fu_idx];
		recover_fl_head_o = fl_head_r[fu_idx];
		resolve_mask_o    = comp_br ? br_mask_r[fu_idx] : '0; // frees the slot either way
	end

	always_comb begin
		for (int i = 0; i < ROB_DEPTH; i++) begin
			squash[i] = mispredict && ((idx_t'(i) - head_idx) > fu_off);
		end
	end

	always_comb begin
		done_nxt = done_r;
		if (fire_i)
			done_nxt[tail_idx] = 1'b0; // fresh entry starts not done
		if (retire_vld)
			done_nxt[head_idx] = 1'b0;
		if (fu_i.valid)
			done_nxt[fu_idx] = 1'b1;
		done_nxt = done_nxt & ~squash;
	end

	// --------------------
	// pointers
	// --------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			done_r <= '0;
		end else begin
			done_r <= done_nxt;
			if (retire_vld)
				head_r <= head_r + ptr_t'(1);
			if (mispredict)
				tail_r <= head_r + ptr_t'(fu_off) + ptr_t'(1); // just after the branch
			else if (fire_i)
				tail_r <= tail_r + ptr_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (fire_i) begin
			disp_r[tail_idx]    <= disp_i;
			new_tag_r[tail_idx] <= new_tag_i;
			old_tag_r[tail_idx] <= old_tag_i;
			br_mask_r[tail_idx] <= br_mask_i;
			fl_head_r[tail_idx] <= fl_head_i + rename_pkg::fl_ptr_t'(1); // skip the tag this entry takes
		end
	end

	// dispatch lands in a free entry or in the one the head vacates
	a_no_fire_full: assert property (@(posedge clk) disable iff (rst)
		fire_i |-> (!full_o || retire_vld));

	// completions only come back for live entries
	a_fu_in_window: assert property (@(posedge clk) disable iff (rst)
		fu_i.valid |-> (ptr_t'(fu_off) < occupancy));

endmodule

`default_nettype wire

//--- source/rename_commit_top.sv
// rename and commit core
`default_nettype none

module rename_commit_top #(
	parameter int ROB_DEPTH = 8
) (
	input  wire  logic                      clk,
	input  wire  logic                      rst,
	input  wire  logic                      disp_valid_i,
	input  wire  rename_pkg::dispatch_req_t disp_i,
	input  wire  rename_pkg::fu_done_t      fu_i,
	output logic                            disp_ready_o,
	output rename_pkg::prf_tag_t            disp_tag_o,
	output rename_pkg::rob_idx_t            disp_rob_idx_o,
	output rename_pkg::retire_t             retire_o,
	output rename_pkg::recovery_t           recover_o
);

	logic                 fire;
	logic                 rob_full;
	logic                 fl_empty;
	logic                 slot_free;
	rename_pkg::prf_tag_t old_tag;
	rename_pkg::br_mask_t br_mask;
	rename_pkg::fl_ptr_t  fl_head;
	rename_pkg::fl_ptr_t  recover_fl_head;
	rename_pkg::br_mask_t resolve_mask;

	// --------------------
	// dispatch handshake
	// --------------------
	always_comb begin
		disp_ready_o = (!rob_full || retire_o.valid)
			&& !fl_empty
			&& (!disp_i.is_br || slot_free)
			&& !recover_o.valid; // hold off while state rolls back
		fire = disp_valid_i && disp_ready_o;
	end

	rob #(
		.ROB_DEPTH(ROB_DEPTH)
	) u_rob (
		.clk               (clk),
		.rst               (rst),
		.fire_i            (fire),
		.disp_i            (disp_i),
		.new_tag_i         (disp_tag_o),
		.old_tag_i         (old_tag),
		.br_mask_i         (br_mask),
		.fl_head_i         (fl_head),
		.fu_i              (fu_i),
		.full_o            (rob_full),
		.tail_idx_o        (disp_rob_idx_o),
		.retire_o          (retire_o),
		.recover_o         (recover_o),
		.recover_fl_head_o (recover_fl_head),
		.resolve_mask_o    (resolve_mask)
	);

	free_list u_free_list (
		.clk            (clk),
		.rst            (rst),
		.pop_i          (fire),
		.push_i         (retire_o.valid),
		.push_tag_i     (retire_o.old_tag),
		.restore_i      (recover_o.valid),
		.restore_head_i (recover_fl_head),
		.tag_o          (disp_tag_o),
		.head_o         (fl_head),
		.empty_o        (fl_empty)
	);

	map_table u_map_table (
		.clk            (clk),
		.rst            (rst),
		.fire_i         (fire),
		.logic_dest_i   (disp_i.logic_dest),
		.new_tag_i      (disp_tag_o),
		.is_br_i        (disp_i.is_br),
		.resolve_mask_i (resolve_mask),
		.restore_i      (recover_o.valid),
		.restore_mask_i (recover_o.br_mask),
		.old_tag_o      (old_tag),
		.br_mask_o      (br_mask),
		.slot_free_o    (slot_free)
	);

endmodule

`default_nettype wire

//--- tb/rename_commit_tb.sv
// rename and commit testbench
`default_nettype none

module rename_commit_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROB_DEPTH = 8;
	localparam int SLOTS     = rename_pkg::BR_SLOTS;

	typedef enum logic [2:0] {K_IDLE, K_DISP, K_COMP, K_READY, K_DRAIN} kind_e;

	typedef struct packed {
		logic [2:0] test;
		kind_e      kind;
		logic [4:0] dest;      // first logical destination
		logic       is_br;
		logic       pred;
		logic [3:0] rep;       // dispatch count or idle cycles
		logic [2:0] nth;       // which dispatch of the test completes
		logic       taken;
		logic       exp_ready;
	} step_t;

	logic                      clk = 1'b0;
	logic                      rst;
	logic                      disp_valid_i;
	rename_pkg::dispatch_req_t disp_i;
	rename_pkg::fu_done_t      fu_i;
	logic                      disp_ready_o;
	rename_pkg::prf_tag_t      disp_tag_o;
	rename_pkg::rob_idx_t      disp_rob_idx_o;
	rename_pkg::retire_t       retire_o;
	rename_pkg::recovery_t     recover_o;

	// --------------------
	// reference model
	// --------------------
	int          free_q [$];
	int          map_m [32];
	int          ckpt_m [ROB_DEPTH][32]; // map after each branch's own rename
	int          e_dest [ROB_DEPTH];
	int          e_new  [ROB_DEPTH];
	int          e_old  [ROB_DEPTH];
	int          e_slot [ROB_DEPTH];
	logic [63:0] e_pc   [ROB_DEPTH];
	logic [1:0]  e_mem  [ROB_DEPTH];
	bit          e_br   [ROB_DEPTH];
	bit          e_pred [ROB_DEPTH];
	bit          e_done [ROB_DEPTH];
	bit          slot_busy [SLOTS];
	int          rob_head;
	int          rob_cnt;
	int          disp_log [$]; // rob indices dispatched in the current test

	step_t       steps [$];
	string       names [7];
	int          cur_test;
	int          test_errs;
	int          total_errs;
	int          checks;
	int          tests_run;
	int          seq;
	bit          stalled;
	logic [31:0] lfsr = 32'h99df;

	always #5 clk = ~clk;

	rename_commit_top #(
		.ROB_DEPTH(ROB_DEPTH)
	) u_rename_commit_top (
		.clk            (clk),
		.rst            (rst),
		.disp_valid_i   (disp_valid_i),
		.disp_i         (disp_i),
		.fu_i           (fu_i),
		.disp_ready_o   (disp_ready_o),
		.disp_tag_o     (disp_tag_o),
		.disp_rob_idx_o (disp_rob_idx_o),
		.retire_o       (retire_o),
		.recover_o      (recover_o)
	);

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val = (val << 1) | int'(lfsr[0]);
			lfsr = galois_step(lfsr);
		end
	endtask

	function automatic int free_slot();
		for (int s = 0; s < SLOTS; s++) begin
			if (!slot_busy[s])
				return s;
		end
		return -1;
	endfunction

	task automatic check_val(input string what, input longint expv, input longint actv);
		checks++;
		assert (expv == actv) else begin
			$display("[ERROR] %s: %s expected %0d actual %0d", names[cur_test], what, expv, actv);
			test_errs++;
		end
	endtask

	task automatic accept(input rename_pkg::dispatch_req_t req, input int idx);
		int dest;
		dest        = int'(req.logic_dest);
		e_dest[idx] = dest;
		e_new[idx]  = free_q.pop_front();
		e_old[idx]  = map_m[dest];
		e_pc[idx]   = req.pc;
		e_mem[idx]  = {req.rd_mem, req.wr_mem};
		e_br[idx]   = req.is_br;
		e_pred[idx] = req.pred_taken;
		e_done[idx] = 1'b0;
		map_m[dest] = e_new[idx];
		if (req.is_br) begin
			e_slot[idx] = free_slot();
			slot_busy[e_slot[idx]] = 1'b1;
			for (int r = 0; r < 32; r++)
				ckpt_m[idx][r] = map_m[r]; // includes the branch's own rename
		end
		rob_cnt++;
		disp_log.push_back(idx);
	endtask

	// squashed tags go back in front of the free list, oldest first
	task automatic roll_back(input int bidx);
		int keep;
		int ri;
		keep = (bidx - rob_head + ROB_DEPTH) % ROB_DEPTH + 1;
		for (int p = rob_cnt - 1; p >= keep; p--) begin
			ri = (rob_head + p) % ROB_DEPTH;
			free_q.push_front(e_new[ri]);
			if (e_br[ri])
				slot_busy[e_slot[ri]] = 1'b0;
		end
		for (int r = 0; r < 32; r++)
			map_m[r] = ckpt_m[bidx][r];
		rob_cnt = keep;
	endtask

	// --------------------
	// one clock cycle, entered and left on a falling edge
	// --------------------
	task automatic run_cycle(input bit want_disp, input rename_pkg::dispatch_req_t req,
			input bit want_comp, input int cidx, input bit ctaken, output bit fired);
		bit ret;
		bit mis;
		bit exp_ready;
		int tail;
		disp_valid_i = want_disp;
		disp_i       = req;
		fu_i.valid   = want_comp;
		fu_i.rob_idx = rename_pkg::rob_idx_t'(cidx);
		fu_i.taken   = ctaken;
		#1;
		ret = rob_cnt > 0 && e_done[rob_head];
		mis = want_comp && e_br[cidx] && (e_pred[cidx] != ctaken);
		exp_ready = (rob_cnt < ROB_DEPTH || ret) && free_q.size() > 0
			&& (!req.is_br || free_slot() >= 0) && !mis;
		check_val("retire valid", ret, retire_o.valid);
		check_val("recover valid", mis, recover_o.valid);
		check_val("ready", exp_ready, disp_ready_o);
		fired = want_disp && disp_ready_o;
		tail  = (rob_head + rob_cnt) % ROB_DEPTH;
		if (fired && exp_ready) begin
			check_val("dispatch tag", free_q[0], disp_tag_o);
			check_val("dispatch index", tail, disp_rob_idx_o);
		end
		if (ret) begin
			check_val("retire dest", e_dest[rob_head], retire_o.logic_dest);
			check_val("retire new tag", e_new[rob_head], retire_o.new_tag);
			check_val("retire old tag", e_old[rob_head], retire_o.old_tag);
			check_val("retire pc", e_pc[rob_head], retire_o.pc);
			check_val("retire mem flags", e_mem[rob_head], {retire_o.rd_mem, retire_o.wr_mem});
			free_q.push_back(e_old[rob_head]);
			rob_head = (rob_head + 1) % ROB_DEPTH;
			rob_cnt--;
		end
		if (fired && exp_ready)
			accept(req, tail); // may reuse the slot the head just left
		if (want_comp) begin
			if (mis) begin
				check_val("recover index", cidx, recover_o.rob_idx);
				check_val("recover mask", 1 << e_slot[cidx], recover_o.br_mask);
			end
			e_done[cidx] = 1'b1;
			if (e_br[cidx])
				slot_busy[e_slot[cidx]] = 1'b0;
			if (mis)
				roll_back(cidx);
		end
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic idle();
		bit f;
		run_cycle(1'b0, '0, 1'b0, 0, 1'b0, f);
	endtask

	task automatic dispatch_one(input int dest, input bit br, input bit pred);
		rename_pkg::dispatch_req_t req;
		bit fired;
		int tries;
		req.logic_dest = rename_pkg::areg_t'(dest);
		req.pc         = 64'h1000 + 64'(seq * 4);
		req.is_br      = br;
		req.pred_taken = pred;
		req.rd_mem     = seq[0];
		req.wr_mem     = seq[1] & ~br;
		seq++;
		fired = 1'b0;
		tries = 0;
		while (!fired && !stalled) begin
			run_cycle(1'b1, req, 1'b0, 0, 1'b0, fired);
			tries++;
			if (!fired && tries >= 30) begin
				$display("%s: dispatch was never accepted", names[cur_test]);
				test_errs++;
				stalled = 1'b1;
			end
		end
	endtask

	// complete what is left, youngest first, then wait for the rob to empty
	task automatic drain();
		int pend [$];
		int tries;
		bit f;
		for (int p = rob_cnt - 1; p >= 0; p--) begin
			if (!e_done[(rob_head + p) % ROB_DEPTH])
				pend.push_back((rob_head + p) % ROB_DEPTH);
		end
		foreach (pend[k])
			run_cycle(1'b0, '0, 1'b1, pend[k], e_pred[pend[k]], f);
		tries = 0;
		while (rob_cnt > 0 && !stalled) begin
			idle();
			tries++;
			if (rob_cnt > 0 && tries >= 20) begin
				$display("%s: rob did not empty", names[cur_test]);
				test_errs++;
				stalled = 1'b1;
			end
		end
	endtask

	task automatic apply_step(input step_t st);
		bit f;
		case (st.kind)
			K_DISP: begin
				for (int k = 0; k < int'(st.rep); k++)
					dispatch_one((int'(st.dest) + k) % 32, st.is_br, st.pred);
			end
			K_COMP: run_cycle(1'b0, '0, 1'b1, disp_log[st.nth], st.taken, f);
			K_READY: begin
				disp_valid_i = 1'b0;
				disp_i       = '0;
				fu_i         = '0;
				#1;
				check_val("ready level", st.exp_ready, disp_ready_o);
				idle();
			end
			K_DRAIN: drain();
			default: repeat (st.rep) idle();
		endcase
	endtask

	task automatic add_step(input int test, input kind_e kind, input int dest, input bit br,
			input bit pred, input int rep, input int nth, input bit taken, input bit rdy);
		step_t st;
		st.test      = 3'(test);
		st.kind      = kind;
		st.dest      = 5'(dest);
		st.is_br     = br;
		st.pred      = pred;
		st.rep       = 4'(rep);
		st.nth       = 3'(nth);
		st.taken     = taken;
		st.exp_ready = rdy;
		steps.push_back(st);
	endtask

	task automatic end_test();
		if (test_errs == 0)
			$display("test %0d %s: ok", cur_test, names[cur_test]);
		else
			$display("test %0d %s: %0d mismatches", cur_test, names[cur_test], test_errs);
		total_errs += test_errs;
		test_errs = 0;
		tests_run++;
	endtask

	initial begin
		int gap;
		rst          = 1'b1;
		disp_valid_i = 1'b0;
		disp_i       = '0;
		fu_i         = '0;
		names[0] = "none";
		names[1] = "reset and first dispatch";
		names[2] = "out of order completion";
		names[3] = "rob full";
		names[4] = "branch predicted right";
		names[5] = "branch mispredict";
		names[6] = "tag reuse";
		for (int t = 32; t < 64; t++)
			free_q.push_back(t);
		for (int r = 0; r < 32; r++)
			map_m[r] = r; // identity map at reset
		rob_head = 0;
		rob_cnt  = 0;

		// test kind     dest br pred rep        nth tkn rdy
		add_step(1, K_DISP,  7,  0, 0,   1,         0,  0,  0);
		add_step(1, K_COMP,  0,  0, 0,   0,         0,  0,  0);
		add_step(1, K_DRAIN, 0,  0, 0,   0,         0,  0,  0);
		add_step(2, K_DISP,  1,  0, 0,   4,         0,  0,  0);
		add_step(2, K_COMP,  0,  0, 0,   0,         3,  0,  0);
		add_step(2, K_COMP,  0,  0, 0,   0,         1,  0,  0);
		add_step(2, K_COMP,  0,  0, 0,   0,         2,  0,  0);
		add_step(2, K_COMP,  0,  0, 0,   0,         0,  0,  0);
		add_step(2, K_DRAIN, 0,  0, 0,   0,         0,  0,  0);
		add_step(3, K_DISP,  10, 0, 0,   ROB_DEPTH, 0,  0,  0);
		add_step(3, K_READY, 0,  0, 0,   0,         0,  0,  0);
		add_step(3, K_COMP,  0,  0, 0,   0,         0,  0,  0);
		add_step(3, K_DISP,  20, 0, 0,   1,         0,  0,  0);
		add_step(3, K_DRAIN, 0,  0, 0,   0,         0,  0,  0);
		add_step(4, K_DISP,  21, 1, 1,   1,         0,  0,  0);
		add_step(4, K_COMP,  0,  0, 0,   0,         0,  1,  0);
		add_step(4, K_DISP,  22, 1, 0,   SLOTS,     0,  0,  0); // needs every slot back
		add_step(4, K_DRAIN, 0,  0, 0,   0,         0,  0,  0);
		add_step(5, K_DISP,  3,  0, 0,   1,         0,  0,  0);
		add_step(5, K_DISP,  4,  1, 0,   1,         0,  0,  0);
		add_step(5, K_DISP,  5,  0, 0,   2,         0,  0,  0);
		add_step(5, K_COMP,  0,  0, 0,   0,         1,  1,  0);
		add_step(5, K_DISP,  5,  0, 0,   1,         0,  0,  0);
		add_step(5, K_DRAIN, 0,  0, 0,   0,         0,  0,  0);
		for (int b = 0; b < 4; b++) begin
			add_step(6, K_DISP,  8 * ((b + 1) % 4), 0, 0, ROB_DEPTH, 0, 0, 0);
			add_step(6, K_DRAIN, 0, 0, 0, 0, 0, 0, 0);
		end
		add_step(6, K_IDLE,  0,  0, 0,   3,         0,  0,  0);

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		cur_test = 1;
		check_val("ready after reset", 1, disp_ready_o);
		check_val("retire after reset", 0, retire_o.valid);
		check_val("recover after reset", 0, recover_o.valid);

		for (int i = 0; i < steps.size() && !stalled; i++) begin
			if (int'(steps[i].test) != cur_test) begin
				end_test();
				cur_test = steps[i].test;
				disp_log.delete();
			end
			apply_step(steps[i]);
			take_bits(2, gap);
			repeat (gap) idle();
		end
		end_test();

		$display("tests: %0d, checks: %0d, mismatches: %0d", tests_run, checks, total_errs);
		if (total_errs == 0 && !stalled)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
source/rename_pkg.sv
source/free_list.sv
source/map_table.sv
source/rob.sv
source/rename_commit_top.sv
tb/rename_commit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rename and commit testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module rename_commit_tb \
	-o tb_sim > sim.log 2>&1 \
	&& ./obj_dir/tb_sim >> sim.log 2>&1 \
	|| echo "build or simulation ended with an error" >> sim.log
cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1
